// ==== dv/az_tb_tasks.svh ====
//////////////////////////////////////////////////////////////////////
// helpers
//////////////////////////////////////////////////////////////////////

// hi minus lo with both operands sign extended to SAMPLE_W+1 bits
function automatic logic signed [SAMPLE_W:0] expected_reading
(
  input logic [SAMPLE_W-1:0] hi,
  input logic [SAMPLE_W-1:0] lo
);
  logic signed [SAMPLE_W:0] hi_x;
  logic signed [SAMPLE_W:0] lo_x;
  hi_x = {hi[SAMPLE_W-1], hi};
  lo_x = {lo[SAMPLE_W-1], lo};
  return hi_x - lo_x;
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
  if (got !== want)
  begin
    $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
    errors++;
  end
endtask

// converter answers hi then lo
task automatic queue_pair(input logic [SAMPLE_W-1:0] hi, input logic [SAMPLE_W-1:0] lo);
  conv_q.push_back(hi);
  conv_q.push_back(lo);
  exp_q.push_back(expected_reading(hi, lo));
endtask

task automatic wait_for_starts(input int target, input int limit, output bit ok);
  int waited;
  waited = 0;
  while (starts_total < target && waited < limit)
  begin
    @(negedge clk);
    waited++;
  end
  ok = (starts_total >= target);
endtask

// run from parked for a number of pairs, then park again
task automatic run_pairs(input int pairs);
  bit ok;
  int target;
  target = starts_total + 2 * pairs;
  @(negedge clk);
  run = 1'b1;
  wait_for_starts(target, pairs * PAIR_CYCLES, ok);
  // dropped during the last lo conversion, so the sequencer parks after it
  run = 1'b0;
  if (!ok)
  begin
    $display("sequencer issued only %0d of %0d conversions", starts_total, target);
    errors++;
  end
endtask

// wait for the readings and compare them in order
task automatic collect_readings(input int count, input string name);
  int                       waited;
  int                       idx;
  logic signed [SAMPLE_W:0] got;
  logic signed [SAMPLE_W:0] want;
  waited = 0;
  idx    = 0;
  while (got_q.size() < count && waited < count * PAIR_CYCLES)
  begin
    @(negedge clk);
    waited++;
  end
  if (got_q.size() < count)
  begin
    $display("%s: only %0d of %0d readings arrived", name, got_q.size(), count);
    errors++;
  end
  while (got_q.size() > 0 && exp_q.size() > 0)
  begin
    got  = got_q.pop_front();
    want = exp_q.pop_front();
    if (got !== want)
    begin
      $display("Mismatch at %0t: %s reading %0d is %0d, expected %0d",
               $time, name, idx, got, want);
      errors++;
    end
    idx++;
  end
  if (got_q.size() != 0 || conv_q.size() != 0)
  begin
    $display("%s: readings or converter samples left over", name);
    errors++;
  end
  got_q.delete();
  exp_q.delete();
  conv_q.delete();
endtask

task automatic check_inactive();
  check_value("conv_start", conv_start, 1'b0);
  check_value("result_valid", result_valid, 1'b0);
  check_value("led0", led0, 1'b0);
  check_value("monitor", monitor, 2'b00);
  check_value("sw_pc_ctl", sw_pc_ctl, SW_PC_BOOT);
  check_value("azmux", azmux, azmux_lo_val);
endtask

task automatic end_test(input string name, input int errors_before);
  if (errors == errors_before)
  begin
    passed++;
    $display("%s: pass", name);
  end
  else
  begin
    failed++;
    $display("%s: fail, %0d errors", name, errors - errors_before);
  end
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

// first pair runs straight out of reset
task automatic reset_state_test();
  int e0;
  e0 = errors;
  repeat (4) @(negedge clk);
  check_inactive();
  queue_pair(24'h000100, 24'h000020);
  repeat (4) @(negedge clk);
  reset = 1'b0;
  @(negedge clk);
  check_inactive();
  run_pairs(1);
  collect_readings(1, "reset_state");
  end_test("reset_state", e0);
endtask

// order and dwell are checked by the switch watcher
task automatic switching_order_test();
  int e0;
  int d0;
  int s0;
  e0 = errors;
  d0 = dwell_checks;
  s0 = starts_total;
  queue_pair(24'h000400, 24'h000010);
  queue_pair(24'h000010, 24'h000400);
  run_pairs(2);
  collect_readings(2, "switching_order");
  check_value("timed dwells", dwell_checks - d0, 4);
  check_value("conv_start count", starts_total - s0, 4);
  end_test("switching_order", e0);
endtask

task automatic arithmetic_test();
  int                  e0;
  logic [SAMPLE_W-1:0] r_hi;
  logic [SAMPLE_W-1:0] r_lo;
  e0   = errors;
  r_hi = SAMPLE_W'($random(seed));
  r_lo = SAMPLE_W'($random(seed));
  queue_pair(24'h000100, 24'h000020);
  queue_pair(24'hffff00, 24'h000050);
  // full scale extremes need the extra bit
  queue_pair(24'h7fffff, 24'h800000);
  queue_pair(24'h800000, 24'h7fffff);
  queue_pair(24'h800000, 24'h800000);
  queue_pair(24'h123456, 24'hfedcba);
  queue_pair(24'h000000, 24'h000001);
  queue_pair(r_hi, r_lo);
  run_pairs(8);
  collect_readings(8, "arithmetic");
  end_test("arithmetic", e0);
endtask

// output full, second lo sample held in capture, sequencer stalled
task automatic backpressure_test();
  int          e0;
  int          s0;
  bit          ok;
  logic [3:0]  mux0;
  logic        pc0;
  az_reading_t held;
  e0 = errors;
  s0 = starts_total;
  queue_pair(24'h001000, 24'h000100);
  queue_pair(24'h800000, 24'h000001);
  queue_pair(24'h000777, 24'h7fffff);
  @(negedge clk);
  result_ready = 1'b0;
  run          = 1'b1;
  wait_for_starts(s0 + 4, 2 * PAIR_CYCLES, ok);
  if (!ok)
  begin
    $display("second pair did not start while the output register was full");
    errors++;
  end
  check_value("result_valid", result_valid, 1'b1);
  held = result;
  mux0 = azmux;
  pc0  = sw_pc_ctl;
  for (int i = 0; i < 150 && errors == e0; i++)
  begin
    @(negedge clk);
    if (starts_total != s0 + 4)
    begin
      $display("conv_start appeared while the sequencer should be stalled");
      errors++;
    end
    check_value("stalled azmux", azmux, mux0);
    check_value("stalled sw_pc_ctl", sw_pc_ctl, pc0);
    check_value("held result_valid", result_valid, 1'b1);
    if (result !== held)
    begin
      $display("Mismatch at %0t: held result moved to %0d", $time, result.value);
      errors++;
    end
  end
  result_ready = 1'b1;
  wait_for_starts(s0 + 6, 2 * PAIR_CYCLES, ok);
  run = 1'b0;
  if (!ok)
  begin
    $display("sequence did not resume after result_ready was raised");
    errors++;
  end
  collect_readings(3, "backpressure");
  end_test("backpressure", e0);
endtask

task automatic run_control_test();
  int e0;
  int s0;
  int waited;
  bit ok;
  e0 = errors;
  s0 = starts_total;
  check_value("parked azmux", azmux, azmux_lo_val);
  check_value("parked sw_pc_ctl", sw_pc_ctl, SW_PC_BOOT);
  for (int i = 0; i < 200 && errors == e0; i++)
  begin
    @(negedge clk);
    if (starts_total != s0)
    begin
      $display("conv_start appeared with run low");
      errors++;
    end
    check_value("parked azmux", azmux, azmux_lo_val);
    check_value("parked sw_pc_ctl", sw_pc_ctl, SW_PC_BOOT);
  end
  queue_pair(24'h0000ff, 24'h0000fe);
  run    = 1'b1;
  waited = 0;
  while (azmux != AZMUX_HI_VAL && waited < 4)
  begin
    @(negedge clk);
    waited++;
  end
  if (azmux != AZMUX_HI_VAL)
  begin
    $display("hi phase did not begin after run was raised");
    errors++;
  end
  wait_for_starts(s0 + 2, PAIR_CYCLES, ok);
  run = 1'b0;
  if (!ok)
  begin
    $display("no hi/lo pair followed the rise of run");
    errors++;
  end
  collect_readings(1, "run_control");
  end_test("run_control", e0);
endtask

// new lo select is taken at the next lo mux step
task automatic lo_mux_test();
  int e0;
  e0 = errors;
  @(negedge clk);
  azmux_lo_val = 4'b0110;
  start_mux_q.delete();
  queue_pair(24'h020000, 24'h010000);
  run_pairs(1);
  collect_readings(1, "lo_mux");
  if (start_mux_q.size() != 2)
  begin
    $display("expected two conversions in the pair, saw %0d", start_mux_q.size());
    errors++;
  end
  else
  begin
    check_value("azmux in hi phase", start_mux_q[0], AZMUX_HI_VAL);
    check_value("azmux in lo phase", start_mux_q[1], 4'b0110);
  end
  check_value("parked azmux", azmux, 4'b0110);
  end_test("lo_mux", e0);
endtask

// ==== dv/az_tb.sv ====
`timescale 1ns/1ps

module az_tb
  import az_pkg::*;
();

  localparam int PRECHARGE_CYCLES = 20;
  // cycle bound on one hi/lo pair including dwells and converter time
  localparam int PAIR_CYCLES      = 3 * PRECHARGE_CYCLES + 40;
  localparam int TIMEOUT_CYCLES   = 40 * PAIR_CYCLES;

  logic                clk;
  logic                reset;
  logic                run;
  logic [3:0]          azmux_lo_val;
  logic                sw_pc_ctl;
  logic [3:0]          azmux;
  logic                led0;
  logic [1:0]          monitor;
  logic                conv_start;
  logic                conv_valid;
  logic [SAMPLE_W-1:0] conv_data;
  logic                result_valid;
  logic                result_ready;
  az_reading_t         result;

  integer seed   = 11254;
  int     errors = 0;
  int     passed = 0;
  int     failed = 0;
  int     cycles = 0;

  // converter answers and expected readings loaded by the tests
  logic [SAMPLE_W-1:0]      conv_q[$];
  logic signed [SAMPLE_W:0] exp_q[$];
  // readings taken from the output port
  logic signed [SAMPLE_W:0] got_q[$];
  // azmux seen at each conv_start
  logic [3:0]               start_mux_q[$];

  // switch watcher state
  logic       prev_pc;
  logic [3:0] prev_mux;
  logic       timed;
  logic       started;
  logic       measuring;
  logic       hi_start;
  int         since_change;
  int         phase_starts;
  int         dwell_checks = 0;
  int         starts_total = 0;

  //////////////////////////////////////////////////////////////////////
  // clock and DUT
  //////////////////////////////////////////////////////////////////////

  initial clk = 1'b0;
  always #4 clk = ~clk;

  az_top #(
    .PRECHARGE_CYCLES (PRECHARGE_CYCLES)
  ) dut_i (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .azmux_lo_val (azmux_lo_val),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .led0         (led0),
    .monitor      (monitor),
    .conv_start   (conv_start),
    .conv_valid   (conv_valid),
    .conv_data    (conv_data),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
  );

  //////////////////////////////////////////////////////////////////////
  // converter model
  //////////////////////////////////////////////////////////////////////

  // answers each conv_start after 3 to 12 cycles with the next queued value
  initial
  begin
    int delay;
    conv_valid = 1'b0;
    conv_data  = '0;
    forever
    begin
      @(negedge clk);
      if (conv_start === 1'b1)
      begin
        delay = 3 + (($random(seed) & 32'h7fffffff) % 10);
        repeat (delay - 1) @(negedge clk);
        if (conv_q.size() == 0)
        begin
          $display("converter was started at %0t with no sample queued", $time);
          errors++;
          conv_data = '0;
        end
        else
          conv_data = conv_q.pop_front();
        conv_valid = 1'b1;
        @(negedge clk);
        conv_valid = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // watchers sampled on the rising edge
  //////////////////////////////////////////////////////////////////////

  // readings leave on valid and ready
  always @(posedge clk)
    if (!reset && result_valid && result_ready)
      got_q.push_back(result.value);

  // switching order, dwell length and one conv_start per phase
  always @(posedge clk)
  begin
    if (reset)
    begin
      prev_pc      = SW_PC_BOOT;
      prev_mux     = azmux;
      timed        = 1'b0;
      started      = 1'b0;
      since_change = 0;
      phase_starts = 0;
    end
    else
    begin
      since_change++;
      if (conv_start)
      begin
        // first start of each pair is the hi conversion
        hi_start = (starts_total % 2 == 0);
        check_value("led0 at conv_start", led0, hi_start);
        check_value("monitor at conv_start", monitor, {hi_start, hi_start});
        starts_total++;
        phase_starts++;
        start_mux_q.push_back(azmux);
      end
      if (sw_pc_ctl == SW_PC_SIGNAL && azmux != AZMUX_HI_VAL)
      begin
        $display("pre-charge switch at signal while azmux is not at hi, %0t", $time);
        errors++;
      end
      if (sw_pc_ctl !== prev_pc || azmux !== prev_mux)
      begin
        // only the dwells after mux to hi and pc to boot have a fixed length
        if (timed && since_change != PRECHARGE_CYCLES + 1)
        begin
          $display("Mismatch at %0t: dwell of %0d cycles, expected %0d",
                   $time, since_change, PRECHARGE_CYCLES + 1);
          errors++;
        end
        if (timed)
          dwell_checks++;
        // hi phase has pc at signal and lo phase has mux at lo once running
        measuring = (prev_pc == SW_PC_SIGNAL) || (started && prev_mux != AZMUX_HI_VAL);
        if (phase_starts != (measuring ? 1 : 0))
        begin
          $display("Mismatch at %0t: %0d conv_start pulses in a phase, expected %0d",
                   $time, phase_starts, measuring ? 1 : 0);
          errors++;
        end
        timed = (azmux == AZMUX_HI_VAL && prev_mux != AZMUX_HI_VAL) ||
                (sw_pc_ctl == SW_PC_BOOT && prev_pc == SW_PC_SIGNAL);
        if (azmux == AZMUX_HI_VAL)
          started = 1'b1;
        since_change = 0;
        phase_starts = 0;
        prev_pc      = sw_pc_ctl;
        prev_mux     = azmux;
      end
    end
  end

  // hard stop in case the DUT hangs
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  `include "az_tb_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    reset        = 1'b1;
    run          = 1'b0;
    azmux_lo_val = 4'b0001;
    result_ready = 1'b1;

    reset_state_test();
    switching_order_test();
    arithmetic_test();
    backpressure_test();
    run_control_test();
    lo_mux_test();

    $display("pass count %0d, fail count %0d", passed, failed);
    if (failed == 0 && errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+dv
logic/az_pkg.sv
logic/az_sequencer.sv
logic/az_capture.sv
logic/az_subtract.sv
logic/az_top.sv
dv/az_tb.sv

// ==== logic/az_capture.sv ====
`timescale 1ns/1ps

module az_capture
  import az_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                meas_start,
  input  az_request_t         meas_req,
  input  logic                conv_valid,
  input  logic [SAMPLE_W-1:0] conv_data,
  input  logic                sample_ready,
  output logic                conv_start,
  output logic                sample_valid,
  output az_sample_t          sample,
  output logic                meas_done
);

  // a conversion has been started and its result not yet seen
  logic       pending;
  // phase of the outstanding request
  az_phase_e  phase_q;
  az_sample_t sample_q;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      conv_start   <= 1'b0;
      pending      <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      // converter start follows the request by one cycle
      conv_start <= meas_start;

      if (meas_start)
        pending <= 1'b1;
      else if (pending && conv_valid)
        pending <= 1'b0;

      // result captured, offer it downstream until accepted
      if (pending && conv_valid)
        sample_valid <= 1'b1;
      else if (sample_valid && sample_ready)
        sample_valid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (meas_start)
      phase_q <= meas_req.phase;

    // stray conv_valid with nothing outstanding leaves the register alone
    if (pending && conv_valid)
    begin
      sample_q.phase <= phase_q;
      sample_q.data  <= conv_data;
    end
  end

  assign sample = sample_q;

  // completion only once the subtractor has taken the sample
  assign meas_done = sample_valid && sample_ready;

endmodule

// ==== logic/az_pkg.sv ====
package az_pkg;

  //////////////////////////////////////////////////////////////////////
  // converter result width
  //////////////////////////////////////////////////////////////////////

  parameter int SAMPLE_W = 24;

  // which half of the auto-zero cycle a conversion belongs to
  typedef enum logic
  {
    PHASE_HI = 1'b0,
    PHASE_LO = 1'b1
  } az_phase_e;

  //////////////////////////////////////////////////////////////////////
  // analog switch codes
  //////////////////////////////////////////////////////////////////////

  // pre-charge switch levels
  parameter logic SW_PC_BOOT   = 1'b0;
  parameter logic SW_PC_SIGNAL = 1'b1;

  // az mux code for S1, the pre-charge output used as the hi input
  parameter logic [3:0] AZMUX_HI_VAL = 4'b1000;

  //////////////////////////////////////////////////////////////////////
  // payloads
  //////////////////////////////////////////////////////////////////////

  // conversion request, travels with a one cycle start strobe
  typedef struct packed
  {
    az_phase_e phase;
  } az_request_t;

  // converter result tagged with its phase
  typedef struct packed
  {
    az_phase_e                  phase;
    logic signed [SAMPLE_W-1:0] data;
  } az_sample_t;

  // hi minus lo, one extra bit so the difference cannot overflow
  typedef struct packed
  {
    logic signed [SAMPLE_W:0] value;
  } az_reading_t;

endpackage

// ==== logic/az_sequencer.sv ====
`timescale 1ns/1ps

module az_sequencer
  import az_pkg::*;
#(
  parameter int PRECHARGE_CYCLES = 10000
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  logic [3:0]  azmux_lo_val,
  input  logic        meas_done,
  output logic        meas_start,
  output az_request_t meas_req,
  output logic        sw_pc_ctl,
  output logic [3:0]  azmux,
  output logic        led0,
  output logic [1:0]  monitor
);

  // dwell counter just wide enough for the precharge count
  localparam int CNT_W = ($clog2(PRECHARGE_CYCLES + 1) > 0) ?
                         $clog2(PRECHARGE_CYCLES + 1) : 1;
  localparam logic [CNT_W-1:0] DWELL = CNT_W'(PRECHARGE_CYCLES);

  typedef enum logic [2:0]
  {
    S_INIT,
    S_SETTLE,
    S_HI_WAIT,
    S_PROTECT,
    S_LO_WAIT,
    S_PARK
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] cnt;

  // mux position, hi or lo
  logic       mux_hi;
  // set once a lo value has been captured at a lo mux step
  logic       lo_held;
  logic [3:0] lo_val_q;

  //////////////////////////////////////////////////////////////////////
  // switch outputs
  //////////////////////////////////////////////////////////////////////

  // before the first lo step the mux simply follows the lo select input
  assign azmux = mux_hi  ? AZMUX_HI_VAL :
                 lo_held ? lo_val_q     : azmux_lo_val;

  // scope probes
  // bit 0 mux at hi, bit 1 pc at signal
  assign monitor = {sw_pc_ctl == SW_PC_SIGNAL, mux_hi};

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  // each change of switch or mux is done on the edge where the dwell
  // counter reads zero, so change to change is PRECHARGE_CYCLES+1
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= S_INIT;
      cnt        <= DWELL;
      mux_hi     <= 1'b0;
      lo_held    <= 1'b0;
      sw_pc_ctl  <= SW_PC_BOOT;
      meas_start <= 1'b0;
      meas_req   <= '{phase: PHASE_HI};
      led0       <= 1'b0;
    end
    else
    begin
      // start is a single cycle strobe
      meas_start <= 1'b0;

      case (state)
        // hold pc at boot, mux at lo, one dwell before leaving reset state
        S_INIT:
          if (cnt == '0)
          begin
            mux_hi <= 1'b1;
            cnt    <= DWELL;
            state  <= S_SETTLE;
          end
          else
            cnt <= cnt - 1'b1;

        // mux at hi with signal still protected by pc at boot
        // then switch pc to signal and take the hi measurement
        S_SETTLE:
          if (cnt == '0)
          begin
            sw_pc_ctl      <= SW_PC_SIGNAL;
            led0           <= 1'b1;
            meas_start     <= 1'b1;
            meas_req.phase <= PHASE_HI;
            state          <= S_HI_WAIT;
          end
          else
            cnt <= cnt - 1'b1;

        // wait for the hi sample to be accepted downstream
        S_HI_WAIT:
          if (meas_done)
          begin
            sw_pc_ctl <= SW_PC_BOOT;
            cnt       <= DWELL;
            state     <= S_PROTECT;
          end

        // pc back at boot protects the signal before the mux moves to lo
        S_PROTECT:
          if (cnt == '0)
          begin
            mux_hi         <= 1'b0;
            lo_val_q       <= azmux_lo_val;
            lo_held        <= 1'b1;
            led0           <= 1'b0;
            meas_start     <= 1'b1;
            meas_req.phase <= PHASE_LO;
            state          <= S_LO_WAIT;
          end
          else
            cnt <= cnt - 1'b1;

        // lo measurement, then decide on another pair
        S_LO_WAIT:
          if (meas_done)
          begin
            if (run)
            begin
              mux_hi <= 1'b1;
              cnt    <= DWELL;
              state  <= S_SETTLE;
            end
            else
              state <= S_PARK;
          end

        // parked with pc at boot and mux at lo
        S_PARK:
          if (run)
          begin
            mux_hi <= 1'b1;
            cnt    <= DWELL;
            state  <= S_SETTLE;
          end

        default:
          state <= S_INIT;
      endcase
    end
  end

endmodule

// ==== logic/az_subtract.sv ====
`timescale 1ns/1ps

module az_subtract
  import az_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        sample_valid,
  input  az_sample_t  sample,
  input  logic        result_ready,
  output logic        sample_ready,
  output logic        result_valid,
  output az_reading_t result
);

  // latest hi sample
  logic signed [SAMPLE_W-1:0] hi_q;

  // sign extended operands
  logic signed [SAMPLE_W:0]   hi_ext;
  logic signed [SAMPLE_W:0]   lo_ext;

  logic is_lo;
  logic take;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  assign is_lo = (sample.phase == PHASE_LO);

  // hi samples always go in
  // lo only when the output register is free or being emptied now
  assign sample_ready = !is_lo || !result_valid || result_ready;

  assign take = sample_valid && sample_ready;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      result_valid <= 1'b0;
    else if (take && is_lo)
      result_valid <= 1'b1;
    else if (result_ready)
      result_valid <= 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // hi minus lo
  //////////////////////////////////////////////////////////////////////

  assign hi_ext = hi_q;
  assign lo_ext = sample.data;

  always_ff @(posedge clk)
  begin
    if (take && !is_lo)
      hi_q <= sample.data;

    // one extra bit, so full scale hi minus full scale lo still fits
    if (take && is_lo)
      result.value <= hi_ext - lo_ext;
  end

endmodule

// ==== logic/az_top.sv ====
`timescale 1ns/1ps

module az_top
  import az_pkg::*;
#(
  parameter int PRECHARGE_CYCLES = 10000
)
(
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic [3:0]          azmux_lo_val,
  output logic                sw_pc_ctl,
  output logic [3:0]          azmux,
  output logic                led0,
  output logic [1:0]          monitor,
  output logic                conv_start,
  input  logic                conv_valid,
  input  logic [SAMPLE_W-1:0] conv_data,
  output logic                result_valid,
  input  logic                result_ready,
  output az_reading_t         result
);

  // sequencer to capture
  logic        meas_start;
  az_request_t meas_req;
  logic        meas_done;

  // capture to subtractor
  logic        sample_valid;
  az_sample_t  sample;
  logic        sample_ready;

  //////////////////////////////////////////////////////////////////////
  // switch ordering
  //////////////////////////////////////////////////////////////////////

  az_sequencer #(
    .PRECHARGE_CYCLES (PRECHARGE_CYCLES)
  ) sequencer_i (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .azmux_lo_val (azmux_lo_val),
    .meas_done    (meas_done),
    .meas_start   (meas_start),
    .meas_req     (meas_req),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .led0         (led0),
    .monitor      (monitor)
  );

  // converter handshake and tagging
  az_capture capture_i (
    .clk          (clk),
    .reset        (reset),
    .meas_start   (meas_start),
    .meas_req     (meas_req),
    .conv_valid   (conv_valid),
    .conv_data    (conv_data),
    .sample_ready (sample_ready),
    .conv_start   (conv_start),
    .sample_valid (sample_valid),
    .sample       (sample),
    .meas_done    (meas_done)
  );

  // auto-zeroed reading out
  az_subtract subtract_i (
    .clk          (clk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample       (sample),
    .result_ready (result_ready),
    .sample_ready (sample_ready),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule
